// File: core_pkg.sv
package core_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Basic types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [4:0]  rf_addr_t;
  typedef logic [31:0] word_t;

  // ALU operations, PASS_B carries the link address of JALR
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_B
  } alu_op_e;

  // Operand source, shared by operand a and operand b
  typedef enum logic [1:0] {
    SEL_REGFILE,
    SEL_FW_EX,
    SEL_FW_WB
  } op_a_fw_sel_e;

  // Jump register source, no EX path (stall instead)
  typedef enum logic {
    SELJ_REGFILE,
    SELJ_FW_WB
  } jalr_fw_sel_e;

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline registers
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic  instr_valid;
    word_t pc;
    word_t instr;
  } if_id_pipe_t;

  typedef struct packed {
    logic     instr_valid;
    word_t    pc;
    logic     rf_we;
    rf_addr_t rf_waddr;
    alu_op_e  alu_op;
    word_t    operand_a;
    word_t    operand_b;
    logic     lsu_en;
    logic     lsu_we;
    word_t    store_data;
  } id_ex_pipe_t;

  typedef struct packed {
    logic     instr_valid;
    word_t    pc;
    logic     rf_we;
    rf_addr_t rf_waddr;
    logic     lsu_en;
    logic     lsu_we;
    word_t    result;
    word_t    store_data;
  } ex_wb_pipe_t;

  // RV32I major opcodes of the supported subset
  localparam logic [6:0] OPC_LUI   = 7'b0110111;
  localparam logic [6:0] OPC_OPIMM = 7'b0010011;
  localparam logic [6:0] OPC_OP    = 7'b0110011;
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;
  localparam logic [6:0] OPC_JALR  = 7'b1100111;

  // funct3 values of register ALU ops
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

endpackage

// File: ctrl_byp_if.sv
`timescale 1ns/1ps

interface ctrl_byp_if;
  import core_pkg::*;

  // Forwarding selects for ID
  op_a_fw_sel_e operand_a_fw_mux_sel;
  op_a_fw_sel_e operand_b_fw_mux_sel;
  jalr_fw_sel_e jalr_fw_mux_sel;

  // Hazard stalls, both hold IF and ID
  logic         load_stall;
  logic         jr_stall;

  // Driver side, the bypass controller
  modport ctrl (
    output operand_a_fw_mux_sel, operand_b_fw_mux_sel, jalr_fw_mux_sel,
    output load_stall, jr_stall
  );

  // Pipeline stages
  modport stage (
    input operand_a_fw_mux_sel, operand_b_fw_mux_sel, jalr_fw_mux_sel,
    input load_stall, jr_stall
  );

endinterface

// File: if_stage.sv
`timescale 1ns/1ps

module if_stage #(
  parameter int unsigned IMEM_DEPTH = 64
) (
  input  logic                clk,
  input  logic                rst_i,
  input  logic                fetch_en_i,
  input  logic                imem_we_i,
  input  logic [7:0]          imem_addr_i,
  input  core_pkg::word_t     imem_wdata_i,
  input  logic                jump_valid_i,
  input  core_pkg::word_t     jump_target_i,
  input  logic                id_ready_i,
  ctrl_byp_if.stage           byp,
  output core_pkg::if_id_pipe_t if_id_pipe_o
);
  import core_pkg::*;

  localparam int unsigned IW = $clog2(IMEM_DEPTH);

  word_t imem [IMEM_DEPTH];
  word_t pc;
  logic  jump_taken;

  // Target is only final once no writer of rs1 is pending
  assign jump_taken = jump_valid_i && !byp.jr_stall;

  // External load port
  always_ff @(posedge clk) begin
    if (imem_we_i) begin
      imem[imem_addr_i[IW-1:0]] <= imem_wdata_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // PC and IF/ID register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pc                       <= '0;
      if_id_pipe_o.instr_valid <= 1'b0;
    end else if (id_ready_i) begin
      if (jump_taken) begin
        // Redirect, drop the word fetched behind the JALR
        pc                       <= jump_target_i;
        if_id_pipe_o.instr_valid <= 1'b0;
      end else if (fetch_en_i) begin
        pc                       <= pc + 32'd4;
        if_id_pipe_o.instr_valid <= 1'b1;
        if_id_pipe_o.pc          <= pc;
        if_id_pipe_o.instr       <= imem[pc[IW+1:2]];
      end else begin
        // ID consumed its word and nothing new is fetched
        if_id_pipe_o.instr_valid <= 1'b0;
      end
    end
  end

endmodule

// File: register_file.sv
`timescale 1ns/1ps

module register_file (
  input  logic               clk,
  input  logic               rst_i,
  input  core_pkg::rf_addr_t raddr_i [2],
  output core_pkg::word_t    rdata_o [2],
  input  logic               we_i,
  input  core_pkg::rf_addr_t waddr_i,
  input  core_pkg::word_t    wdata_i
);
  import core_pkg::*;

  // x1 to x31, x0 has no storage
  word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // Asynchronous reads, same-cycle write is covered by WB forwarding
  always_comb begin
    for (int p = 0; p < 2; p++) begin
      rdata_o[p] = (raddr_i[p] == '0) ? '0 : regs[raddr_i[p]];
    end
  end

endmodule

// File: controller_bypass.sv
`timescale 1ns/1ps

module controller_bypass (
  input  logic                  [1:0] rf_re_i,
  input  core_pkg::rf_addr_t    rf_raddr_i [2],
  input  logic                  jalr_id_i,
  input  core_pkg::if_id_pipe_t if_id_pipe_i,
  input  core_pkg::id_ex_pipe_t id_ex_pipe_i,
  input  core_pkg::ex_wb_pipe_t ex_wb_pipe_i,
  input  logic                  wb_ready_i,
  ctrl_byp_if.ctrl              byp
);
  import core_pkg::*;

  logic       id_valid;
  logic       rf_we_ex;
  logic       rf_we_wb;
  logic       lsu_en_ex;
  logic       lsu_en_wb;
  logic       jalr_valid;
  logic [1:0] rd_ex_match;
  logic [1:0] rd_wb_match;
  logic       jr_ex_match;
  logic       jr_wb_match;

  // Qualifiers, decode of an empty ID slot must never stall
  assign id_valid   = if_id_pipe_i.instr_valid;
  assign jalr_valid = jalr_id_i && id_valid;
  assign rf_we_ex   = id_ex_pipe_i.rf_we && id_ex_pipe_i.instr_valid;
  assign rf_we_wb   = ex_wb_pipe_i.rf_we && ex_wb_pipe_i.instr_valid;
  assign lsu_en_ex  = id_ex_pipe_i.lsu_en && id_ex_pipe_i.instr_valid;
  assign lsu_en_wb  = ex_wb_pipe_i.lsu_en && ex_wb_pipe_i.instr_valid;

  // Read address against EX and WB destinations, x0 never matches
  for (genvar i = 0; i < 2; i++) begin : gen_match
    assign rd_ex_match[i] = (rf_raddr_i[i] == id_ex_pipe_i.rf_waddr) && |rf_raddr_i[i] &&
                            rf_re_i[i] && id_valid;
    assign rd_wb_match[i] = (rf_raddr_i[i] == ex_wb_pipe_i.rf_waddr) && |rf_raddr_i[i] &&
                            rf_re_i[i] && id_valid;
  end

  // JALR always reads rs1
  assign jr_ex_match = (rf_raddr_i[0] == id_ex_pipe_i.rf_waddr) && |rf_raddr_i[0];
  assign jr_wb_match = (rf_raddr_i[0] == ex_wb_pipe_i.rf_waddr) && |rf_raddr_i[0];

  ////////////////////////////////////////////////////////////////////////////
  // Stalls
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // Load result not there yet, either still in EX or WB in wait states
    byp.load_stall = (lsu_en_ex && rf_we_ex && |rd_ex_match) ||
                     (!wb_ready_i && rf_we_wb && |rd_wb_match);

    // Target path has no EX forward and no load forward
    byp.jr_stall   = jalr_valid &&
                     ((rf_we_ex && jr_ex_match) ||
                      (rf_we_wb && lsu_en_wb && jr_wb_match));
  end

  ////////////////////////////////////////////////////////////////////////////
  // Forwarding selects
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    byp.operand_a_fw_mux_sel = SEL_REGFILE;
    byp.operand_b_fw_mux_sel = SEL_REGFILE;
    byp.jalr_fw_mux_sel      = SELJ_REGFILE;

    // WB first, EX overrides as the younger writer
    if (rf_we_wb && rd_wb_match[0]) byp.operand_a_fw_mux_sel = SEL_FW_WB;
    if (rf_we_wb && rd_wb_match[1]) byp.operand_b_fw_mux_sel = SEL_FW_WB;
    if (rf_we_ex && rd_ex_match[0]) byp.operand_a_fw_mux_sel = SEL_FW_EX;
    if (rf_we_ex && rd_ex_match[1]) byp.operand_b_fw_mux_sel = SEL_FW_EX;

    // ALU result in WB may feed the jump target
    if (rf_we_wb && jr_wb_match && !lsu_en_wb) begin
      byp.jalr_fw_mux_sel = SELJ_FW_WB;
    end
  end

endmodule

// File: id_stage.sv
`timescale 1ns/1ps

module id_stage (
  input  logic                  clk,
  input  logic                  rst_i,
  input  core_pkg::if_id_pipe_t if_id_pipe_i,
  ctrl_byp_if.stage             byp,
  input  logic                  wb_ready_i,
  output core_pkg::rf_addr_t    rf_raddr_o [2],
  output logic            [1:0] rf_re_o,
  input  core_pkg::word_t       rf_rdata_i [2],
  input  core_pkg::word_t       ex_result_fw_i,
  input  core_pkg::word_t       wb_result_fw_i,
  output logic                  jalr_id_o,
  output logic                  jump_valid_o,
  output core_pkg::word_t       jump_target_o,
  output logic                  id_ready_o,
  output core_pkg::id_ex_pipe_t id_ex_pipe_o
);
  import core_pkg::*;

  word_t    instr;
  word_t    imm_i;
  word_t    imm_s;
  word_t    imm_u;
  word_t    rs1_val;
  word_t    rs2_val;
  word_t    jalr_base;
  logic     rf_we;
  logic     lsu_en;
  logic     lsu_we;
  alu_op_e  alu_op;
  word_t    op_a;
  word_t    op_b;

  assign instr = if_id_pipe_i.instr;
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_u = {instr[31:12], 12'b0};

  assign rf_raddr_o[0] = instr[19:15];
  assign rf_raddr_o[1] = instr[24:20];
  assign jalr_id_o     = (instr[6:0] == OPC_JALR);

  ////////////////////////////////////////////////////////////////////////////
  // Decoder
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    rf_re_o = 2'b00;
    rf_we   = 1'b0;
    lsu_en  = 1'b0;
    lsu_we  = 1'b0;
    alu_op  = ALU_ADD;
    op_a    = rs1_val;
    op_b    = imm_i;
    case (instr[6:0])
      OPC_LUI: begin
        rf_we  = 1'b1;
        alu_op = ALU_PASS_B;
        op_b   = imm_u;
      end
      OPC_OPIMM: begin
        rf_re_o = 2'b01;
        rf_we   = 1'b1;
      end
      OPC_OP: begin
        rf_re_o = 2'b11;
        rf_we   = 1'b1;
        op_b    = rs2_val;
        case (instr[14:12])
          F3_ADD_SUB: alu_op = instr[30] ? ALU_SUB : ALU_ADD;
          F3_XOR:     alu_op = ALU_XOR;
          F3_OR:      alu_op = ALU_OR;
          F3_AND:     alu_op = ALU_AND;
          default:    rf_we  = 1'b0;
        endcase
      end
      OPC_LOAD: begin
        rf_re_o = 2'b01;
        rf_we   = 1'b1;
        lsu_en  = 1'b1;
      end
      OPC_STORE: begin
        // Address from rs1 and imm, data from rs2
        rf_re_o = 2'b11;
        lsu_en  = 1'b1;
        lsu_we  = 1'b1;
        op_b    = imm_s;
      end
      OPC_JALR: begin
        // Link address through the ALU
        rf_re_o = 2'b01;
        rf_we   = 1'b1;
        alu_op  = ALU_PASS_B;
        op_b    = if_id_pipe_i.pc + 32'd4;
      end
      default: ;
    endcase
  end

  // Operand forwarding, EX beats WB beats regfile
  always_comb begin
    case (byp.operand_a_fw_mux_sel)
      SEL_FW_EX: rs1_val = ex_result_fw_i;
      SEL_FW_WB: rs1_val = wb_result_fw_i;
      default:   rs1_val = rf_rdata_i[0];
    endcase
    case (byp.operand_b_fw_mux_sel)
      SEL_FW_EX: rs2_val = ex_result_fw_i;
      SEL_FW_WB: rs2_val = wb_result_fw_i;
      default:   rs2_val = rf_rdata_i[1];
    endcase
  end

  // Jump target, bit 0 cleared
  assign jalr_base     = (byp.jalr_fw_mux_sel == SELJ_FW_WB) ? wb_result_fw_i : rf_rdata_i[0];
  assign jump_target_o = (jalr_base + imm_i) & ~32'd1;
  assign jump_valid_o  = jalr_id_o && if_id_pipe_i.instr_valid;

  assign id_ready_o = wb_ready_i && !byp.load_stall && !byp.jr_stall;

  // ID/EX register, bubble when ID is held
  always_ff @(posedge clk) begin
    if (rst_i) begin
      id_ex_pipe_o.instr_valid <= 1'b0;
    end else if (wb_ready_i) begin
      id_ex_pipe_o.instr_valid <= if_id_pipe_i.instr_valid && id_ready_o;
      id_ex_pipe_o.pc          <= if_id_pipe_i.pc;
      id_ex_pipe_o.rf_we       <= rf_we;
      id_ex_pipe_o.rf_waddr    <= instr[11:7];
      id_ex_pipe_o.alu_op      <= alu_op;
      id_ex_pipe_o.operand_a   <= op_a;
      id_ex_pipe_o.operand_b   <= op_b;
      id_ex_pipe_o.lsu_en      <= lsu_en;
      id_ex_pipe_o.lsu_we      <= lsu_we;
      id_ex_pipe_o.store_data  <= rs2_val;
    end
  end

endmodule

// File: ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
  input  logic                  clk,
  input  logic                  rst_i,
  input  core_pkg::id_ex_pipe_t id_ex_pipe_i,
  input  logic                  wb_ready_i,
  output core_pkg::word_t       ex_result_fw_o,
  output core_pkg::ex_wb_pipe_t ex_wb_pipe_o
);
  import core_pkg::*;

  word_t alu_result;

  // ALU, also forms the load/store address
  always_comb begin
    case (id_ex_pipe_i.alu_op)
      ALU_SUB:    alu_result = id_ex_pipe_i.operand_a - id_ex_pipe_i.operand_b;
      ALU_AND:    alu_result = id_ex_pipe_i.operand_a & id_ex_pipe_i.operand_b;
      ALU_OR:     alu_result = id_ex_pipe_i.operand_a | id_ex_pipe_i.operand_b;
      ALU_XOR:    alu_result = id_ex_pipe_i.operand_a ^ id_ex_pipe_i.operand_b;
      ALU_PASS_B: alu_result = id_ex_pipe_i.operand_b;
      default:    alu_result = id_ex_pipe_i.operand_a + id_ex_pipe_i.operand_b;
    endcase
  end

  // EX forward path, a load here is caught by load_stall
  assign ex_result_fw_o = alu_result;

  // EX/WB register, holds under WB back-pressure
  always_ff @(posedge clk) begin
    if (rst_i) begin
      ex_wb_pipe_o.instr_valid <= 1'b0;
    end else if (wb_ready_i) begin
      ex_wb_pipe_o.instr_valid <= id_ex_pipe_i.instr_valid;
      ex_wb_pipe_o.pc          <= id_ex_pipe_i.pc;
      ex_wb_pipe_o.rf_we       <= id_ex_pipe_i.rf_we;
      ex_wb_pipe_o.rf_waddr    <= id_ex_pipe_i.rf_waddr;
      ex_wb_pipe_o.lsu_en      <= id_ex_pipe_i.lsu_en;
      ex_wb_pipe_o.lsu_we      <= id_ex_pipe_i.lsu_we;
      ex_wb_pipe_o.result      <= alu_result;
      ex_wb_pipe_o.store_data  <= id_ex_pipe_i.store_data;
    end
  end

endmodule

// File: wb_stage.sv
`timescale 1ns/1ps

module wb_stage #(
  parameter int unsigned DMEM_DEPTH = 64,
  parameter int unsigned DMEM_WAIT  = 1
) (
  input  logic                  clk,
  input  logic                  rst_i,
  input  core_pkg::ex_wb_pipe_t ex_wb_pipe_i,
  output logic                  wb_ready_o,
  output core_pkg::word_t       wb_result_fw_o,
  output logic                  rf_we_o,
  output core_pkg::rf_addr_t    rf_waddr_o,
  output core_pkg::word_t       rf_wdata_o,
  output logic                  retire_valid_o,
  output core_pkg::word_t       retire_pc_o,
  output logic                  retire_we_o,
  output core_pkg::rf_addr_t    retire_waddr_o,
  output core_pkg::word_t       retire_wdata_o
);
  import core_pkg::*;

  localparam int unsigned DW = $clog2(DMEM_DEPTH);
  // At least one bit, DMEM_WAIT may be zero
  localparam int unsigned CW = (DMEM_WAIT > 0) ? $clog2(DMEM_WAIT + 1) : 1;

  word_t          dmem [DMEM_DEPTH];
  logic  [CW-1:0] wait_cnt;
  logic  [DW-1:0] dmem_idx;
  logic           mem_access;
  logic           complete;

  // Word addressed, byte offset dropped
  assign dmem_idx   = ex_wb_pipe_i.result[DW+1:2];
  assign mem_access = ex_wb_pipe_i.instr_valid && ex_wb_pipe_i.lsu_en;

  // Access takes DMEM_WAIT+1 cycles in WB
  assign wb_ready_o = !mem_access || (wait_cnt == CW'(DMEM_WAIT));
  assign complete   = ex_wb_pipe_i.instr_valid && wb_ready_o;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      wait_cnt <= '0;
    end else if (mem_access && !wb_ready_o) begin
      wait_cnt <= wait_cnt + 1'b1;
    end else begin
      wait_cnt <= '0;
    end
  end

  // Store commits in the last wait cycle
  always_ff @(posedge clk) begin
    if (mem_access && ex_wb_pipe_i.lsu_we && wb_ready_o) begin
      dmem[dmem_idx] <= ex_wb_pipe_i.store_data;
    end
  end

  assign wb_result_fw_o = ex_wb_pipe_i.lsu_en ? dmem[dmem_idx] : ex_wb_pipe_i.result;

  // Writeback
  assign rf_we_o    = complete && ex_wb_pipe_i.rf_we;
  assign rf_waddr_o = ex_wb_pipe_i.rf_waddr;
  assign rf_wdata_o = wb_result_fw_o;

  // Trace, one pulse per completed instruction
  assign retire_valid_o = complete;
  assign retire_pc_o    = ex_wb_pipe_i.pc;
  assign retire_we_o    = rf_we_o;
  assign retire_waddr_o = ex_wb_pipe_i.rf_waddr;
  assign retire_wdata_o = wb_result_fw_o;

endmodule

// File: core_top.sv
`timescale 1ns/1ps

module core_top #(
  parameter int unsigned IMEM_DEPTH = 64,
  parameter int unsigned DMEM_DEPTH = 64,
  parameter int unsigned DMEM_WAIT  = 1
) (
  input  logic        clk,
  input  logic        rst_i,
  input  logic        fetch_en_i,
  input  logic        imem_we_i,
  input  logic [7:0]  imem_addr_i,
  input  logic [31:0] imem_wdata_i,
  output logic        retire_valid_o,
  output logic [31:0] retire_pc_o,
  output logic        retire_we_o,
  output logic [4:0]  retire_waddr_o,
  output logic [31:0] retire_wdata_o
);
  import core_pkg::*;

  // Pipeline registers
  if_id_pipe_t if_id_pipe;
  id_ex_pipe_t id_ex_pipe;
  ex_wb_pipe_t ex_wb_pipe;

  // Register file ports
  rf_addr_t   rf_raddr [2];
  word_t      rf_rdata [2];
  logic [1:0] rf_re;
  logic       rf_we;
  rf_addr_t   rf_waddr;
  word_t      rf_wdata;

  // Control and forward paths
  logic  jalr_id;
  logic  jump_valid;
  word_t jump_target;
  logic  id_ready;
  logic  wb_ready;
  word_t ex_result_fw;
  word_t wb_result_fw;

  ctrl_byp_if byp_if ();

  ////////////////////////////////////////////////////////////////////////////
  // Stages
  ////////////////////////////////////////////////////////////////////////////

  if_stage #(.IMEM_DEPTH(IMEM_DEPTH)) if_stage_i (
    .clk, .rst_i, .fetch_en_i, .imem_we_i, .imem_addr_i, .imem_wdata_i,
    .jump_valid_i(jump_valid), .jump_target_i(jump_target), .id_ready_i(id_ready),
    .byp(byp_if.stage), .if_id_pipe_o(if_id_pipe)
  );

  id_stage id_stage_i (
    .clk, .rst_i, .if_id_pipe_i(if_id_pipe), .byp(byp_if.stage), .wb_ready_i(wb_ready),
    .rf_raddr_o(rf_raddr), .rf_re_o(rf_re), .rf_rdata_i(rf_rdata),
    .ex_result_fw_i(ex_result_fw), .wb_result_fw_i(wb_result_fw),
    .jalr_id_o(jalr_id), .jump_valid_o(jump_valid), .jump_target_o(jump_target),
    .id_ready_o(id_ready), .id_ex_pipe_o(id_ex_pipe)
  );

  register_file register_file_i (
    .clk, .rst_i, .raddr_i(rf_raddr), .rdata_o(rf_rdata),
    .we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata)
  );

  controller_bypass controller_bypass_i (
    .rf_re_i(rf_re), .rf_raddr_i(rf_raddr), .jalr_id_i(jalr_id),
    .if_id_pipe_i(if_id_pipe), .id_ex_pipe_i(id_ex_pipe), .ex_wb_pipe_i(ex_wb_pipe),
    .wb_ready_i(wb_ready), .byp(byp_if.ctrl)
  );

  ex_stage ex_stage_i (
    .clk, .rst_i, .id_ex_pipe_i(id_ex_pipe), .wb_ready_i(wb_ready),
    .ex_result_fw_o(ex_result_fw), .ex_wb_pipe_o(ex_wb_pipe)
  );

  wb_stage #(.DMEM_DEPTH(DMEM_DEPTH), .DMEM_WAIT(DMEM_WAIT)) wb_stage_i (
    .clk, .rst_i, .ex_wb_pipe_i(ex_wb_pipe), .wb_ready_o(wb_ready),
    .wb_result_fw_o(wb_result_fw), .rf_we_o(rf_we), .rf_waddr_o(rf_waddr),
    .rf_wdata_o(rf_wdata), .retire_valid_o, .retire_pc_o, .retire_we_o,
    .retire_waddr_o, .retire_wdata_o
  );

endmodule

// File: tb_core_top.sv
`timescale 1ns/1ps

module tb_core_top;

  localparam int IMEM_DEPTH = 64;
  localparam int DMEM_DEPTH = 64;
  localparam int DMEM_WAIT  = 2;
  localparam int NUM_TESTS  = 6;
  localparam int MAX_STEPS  = 256;

  // RV32I encoding fields used by the program
  localparam logic [6:0] OP_LUI   = 7'b0110111;
  localparam logic [6:0] OP_OPIMM = 7'b0010011;
  localparam logic [6:0] OP_OP    = 7'b0110011;
  localparam logic [6:0] OP_LOAD  = 7'b0000011;
  localparam logic [6:0] OP_STORE = 7'b0100011;
  localparam logic [6:0] OP_JALR  = 7'b1100111;
  localparam logic [6:0] F7_BASE  = 7'b0000000;
  localparam logic [6:0] F7_SUB   = 7'b0100000;
  localparam logic [2:0] F3_ADD   = 3'b000;
  localparam logic [2:0] F3_XOR   = 3'b100;
  localparam logic [2:0] F3_OR    = 3'b110;
  localparam logic [2:0] F3_AND   = 3'b111;

  // One expected trace entry, test is the program section it came from
  typedef struct {
    logic [31:0] pc;
    logic        we;
    logic [4:0]  waddr;
    logic [31:0] wdata;
    int          test;
  } retire_t;

  logic        clk;
  logic        rst_i;
  logic        fetch_en_i;
  logic        imem_we_i;
  logic [7:0]  imem_addr_i;
  logic [31:0] imem_wdata_i;
  logic        retire_valid_o;
  logic [31:0] retire_pc_o;
  logic        retire_we_o;
  logic [4:0]  retire_waddr_o;
  logic [31:0] retire_wdata_o;

  logic [31:0] prog [$];
  int          prog_test [$];
  retire_t     exp_q [$];
  string       test_name [NUM_TESTS] = '{"alu and immediates", "ex and wb forwarding",
                                         "load-use stall", "stores then loads", "jalr",
                                         "random block"};
  int          test_err [NUM_TESTS] = '{default: 0};
  int          exp_idx = 0;
  int          err_count = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;
  logic        done = 1'b0;
  logic        timed_out = 1'b0;
  integer      seed;

  core_top #(
    .IMEM_DEPTH(IMEM_DEPTH),
    .DMEM_DEPTH(DMEM_DEPTH),
    .DMEM_WAIT (DMEM_WAIT)
  ) dut_i (
    .clk, .rst_i, .fetch_en_i, .imem_we_i, .imem_addr_i, .imem_wdata_i,
    .retire_valid_o, .retire_pc_o, .retire_we_o, .retire_waddr_o, .retire_wdata_o
  );

  always #10 clk = ~clk;

  initial begin
    rst_i = 1'b1;
    repeat (5) @(posedge clk);
    rst_i <= 1'b0;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Instruction encoders
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lui(int rd, int imm);
    return {imm[19:0], rd[4:0], OP_LUI};
  endfunction

  function automatic logic [31:0] addi(int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], F3_ADD, rd[4:0], OP_OPIMM};
  endfunction

  function automatic logic [31:0] op_rr(logic [6:0] f7, logic [2:0] f3, int rd, int rs1,
                                        int rs2);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OP_OP};
  endfunction

  function automatic logic [31:0] lw(int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], OP_LOAD};
  endfunction

  function automatic logic [31:0] sw(int rs2, int rs1, int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OP_STORE};
  endfunction

  function automatic logic [31:0] jalr(int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], OP_JALR};
  endfunction

  function automatic int next_pc();
    return prog.size() * 4;
  endfunction

  task automatic append_word(logic [31:0] word, int test);
    prog.push_back(word);
    prog_test.push_back(test);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Program, one section per test
  ////////////////////////////////////////////////////////////////////////////

  task automatic build_program();
    logic [31:0] r;
    int          p;
    int          rd;
    int          rs1;
    int          rs2;
    append_word(lui(1, 'h12345), 0);
    append_word(addi(2, 0, 2032), 0);
    append_word(addi(3, 0, -5), 0);
    append_word(op_rr(F7_BASE, F3_ADD, 4, 2, 3), 0);
    append_word(op_rr(F7_SUB, F3_ADD, 5, 2, 3), 0);
    append_word(op_rr(F7_BASE, F3_AND, 6, 1, 3), 0);
    append_word(op_rr(F7_BASE, F3_OR, 7, 2, 1), 0);
    append_word(op_rr(F7_BASE, F3_XOR, 8, 3, 2), 0);
    // Dependent chains hit EX and WB on both operands
    append_word(addi(10, 0, 100), 1);
    append_word(addi(11, 10, 1), 1);
    append_word(op_rr(F7_BASE, F3_ADD, 12, 11, 10), 1);
    append_word(op_rr(F7_SUB, F3_ADD, 13, 12, 12), 1);
    append_word(op_rr(F7_BASE, F3_XOR, 14, 11, 12), 1);
    append_word(op_rr(F7_BASE, F3_OR, 15, 14, 13), 1);
    // Use right after the load, then one slot later
    append_word(sw(12, 0, 8), 2);
    append_word(lw(16, 0, 8), 2);
    append_word(addi(17, 16, 1), 2);
    append_word(lw(18, 0, 8), 2);
    append_word(addi(19, 0, 3), 2);
    append_word(op_rr(F7_BASE, F3_ADD, 20, 18, 19), 2);
    append_word(sw(1, 0, 16), 3);
    append_word(sw(5, 0, 20), 3);
    append_word(sw(15, 10, 24), 3);
    append_word(lw(21, 0, 16), 3);
    append_word(lw(22, 0, 20), 3);
    append_word(lw(23, 0, 124), 3);
    append_word(op_rr(F7_SUB, F3_ADD, 24, 21, 22), 3);
    // JALR right behind an ALU writer of rs1
    p = next_pc();
    append_word(addi(25, 0, p + 12), 4);
    append_word(jalr(26, 25, 0), 4);
    append_word(addi(27, 0, 99), 4);
    append_word(addi(27, 0, 1), 4);
    // JALR behind a load of rs1, two words skipped
    p = next_pc();
    append_word(addi(28, 0, p + 20), 4);
    append_word(sw(28, 0, 32), 4);
    append_word(lw(29, 0, 32), 4);
    append_word(jalr(30, 29, 4), 4);
    append_word(addi(27, 0, 98), 4);
    append_word(addi(27, 0, 97), 4);
    append_word(addi(31, 30, 0), 4);
    // Target from WB, odd offset tests bit 0 clearing
    p = next_pc();
    append_word(addi(9, 0, p + 16), 4);
    append_word(addi(0, 0, 0), 4);
    append_word(jalr(26, 9, 1), 4);
    append_word(addi(27, 0, 96), 4);
    append_word(op_rr(F7_BASE, F3_ADD, 27, 26, 31), 4);
    for (int i = 0; i < 16; i++) begin
      r   = $random(seed);
      rd  = int'(r[7:3]);
      rs1 = int'(r[12:8]);
      rs2 = int'(r[17:13]);
      case (r[2:0])
        3'd0:    append_word(lui(rd, int'(r[31:12])), 5);
        3'd1:    append_word(addi(rd, rs1, int'(r[31:20])), 5);
        3'd2:    append_word(op_rr(F7_BASE, F3_ADD, rd, rs1, rs2), 5);
        3'd3:    append_word(op_rr(F7_SUB, F3_ADD, rd, rs1, rs2), 5);
        3'd4:    append_word(op_rr(F7_BASE, F3_AND, rd, rs1, rs2), 5);
        3'd5:    append_word(op_rr(F7_BASE, F3_OR, rd, rs1, rs2), 5);
        default: append_word(op_rr(F7_BASE, F3_XOR, rd, rs1, rs2), 5);
      endcase
    end
    // x0 write, read back, then park in a self loop
    append_word(addi(0, 5, 7), 5);
    append_word(op_rr(F7_BASE, F3_ADD, 6, 0, 0), 5);
    p = next_pc();
    append_word(jalr(0, 0, p), 5);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Architectural model, one trace entry per executed instruction
  ////////////////////////////////////////////////////////////////////////////

  function automatic void run_model();
    logic [31:0] regs [32];
    logic [31:0] mem [64];
    logic [31:0] pc;
    logic [31:0] ins;
    logic [31:0] rs1v;
    logic [31:0] rs2v;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] res;
    logic [31:0] addr;
    logic [31:0] nxt;
    logic        we;
    logic        halt;
    int          idx;
    retire_t     ent;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    for (int i = 0; i < 64; i++) begin
      mem[i] = '0;
    end
    pc   = '0;
    halt = 1'b0;
    for (int step = 0; step < MAX_STEPS && !halt; step++) begin
      idx = int'(pc[31:2]);
      if (idx >= prog.size()) begin
        halt = 1'b1;
      end else begin
        ins   = prog[idx];
        rs1v  = (ins[19:15] == 5'd0) ? '0 : regs[ins[19:15]];
        rs2v  = (ins[24:20] == 5'd0) ? '0 : regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        nxt   = pc + 32'd4;
        we    = 1'b1;
        res   = '0;
        case (ins[6:0])
          OP_LUI:   res = {ins[31:12], 12'h000};
          OP_OPIMM: res = rs1v + imm_i;
          OP_OP: begin
            case (ins[14:12])
              F3_XOR:  res = rs1v ^ rs2v;
              F3_OR:   res = rs1v | rs2v;
              F3_AND:  res = rs1v & rs2v;
              default: res = ins[30] ? rs1v - rs2v : rs1v + rs2v;
            endcase
          end
          OP_LOAD: begin
            addr = rs1v + imm_i;
            res  = mem[addr[7:2]];
          end
          OP_STORE: begin
            addr = rs1v + imm_s;
            mem[addr[7:2]] = rs2v;
            we = 1'b0;
          end
          OP_JALR: begin
            res  = pc + 32'd4;
            nxt  = (rs1v + imm_i) & ~32'd1;
            halt = (nxt == pc);
          end
          default: we = 1'b0;
        endcase
        ent.pc    = pc;
        ent.we    = we;
        ent.waddr = ins[11:7];
        ent.wdata = res;
        ent.test  = prog_test[idx];
        exp_q.push_back(ent);
        if (we && ins[11:7] != 5'd0) begin
          regs[ins[11:7]] = res;
        end
        pc = nxt;
      end
    end
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Trace comparison
  ////////////////////////////////////////////////////////////////////////////

  task automatic show_mismatch(string name, logic [31:0] got, logic [31:0] want);
    $display("Mismatch at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, want);
  endtask

  task automatic close_test(int t);
    if (test_err[t] == 0) begin
      $display("Test %0d (%s): ok", t + 1, test_name[t]);
    end else begin
      $display("Test %0d (%s): %0d errors", t + 1, test_name[t], test_err[t]);
    end
  endtask

  task automatic check_retire();
    retire_t e;
    int      errs;
    e    = exp_q[exp_idx];
    errs = 0;
    assert (retire_pc_o === e.pc) else begin
      show_mismatch("retire_pc_o", retire_pc_o, e.pc);
      errs++;
    end
    assert (retire_we_o === e.we) else begin
      show_mismatch("retire_we_o", 32'(retire_we_o), 32'(e.we));
      errs++;
    end
    // Address and data only mean something for a register write
    if (e.we) begin
      assert (retire_waddr_o === e.waddr) else begin
        show_mismatch("retire_waddr_o", 32'(retire_waddr_o), 32'(e.waddr));
        errs++;
      end
      assert (retire_wdata_o === e.wdata) else begin
        show_mismatch("retire_wdata_o", retire_wdata_o, e.wdata);
        errs++;
      end
    end
    err_count      += errs;
    test_err[e.test] += errs;
    exp_idx++;
    if (exp_idx == exp_q.size()) begin
      close_test(e.test);
      done = 1'b1;
    end else if (exp_q[exp_idx].test != e.test) begin
      close_test(e.test);
    end
  endtask

  // Outputs settle mid cycle, each retiring cycle is seen once
  always @(negedge clk) begin
    if (!rst_i && !done && retire_valid_o === 1'b1) begin
      check_retire();
    end
  end

  always @(posedge clk) begin
    if (fetch_en_i && !done && !timed_out) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
        timed_out <= 1'b1;
      end
    end
  end

  initial begin
    clk          = 1'b0;
    fetch_en_i   = 1'b0;
    imem_we_i    = 1'b0;
    imem_addr_i  = '0;
    imem_wdata_i = '0;
    seed         = 32'h26e;
    build_program();
    run_model();
    cycle_limit = exp_q.size() * (DMEM_WAIT + 4) + 50;
    // Loading starts under reset, fetch waits for the last word
    foreach (prog[i]) begin
      @(posedge clk);
      imem_we_i    <= 1'b1;
      imem_addr_i  <= 8'(i);
      imem_wdata_i <= prog[i];
    end
    @(posedge clk);
    imem_we_i  <= 1'b0;
    fetch_en_i <= 1'b1;
    while (!done && !timed_out) begin
      @(posedge clk);
    end
    if (timed_out) begin
      $display("Timeout: only %0d of %0d retirements seen after %0d cycles",
               exp_idx, exp_q.size(), cycle_count);
    end
    $display("Checked %0d of %0d retirements, %0d errors", exp_idx, exp_q.size(), err_count);
    if (err_count == 0 && !timed_out) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: sim.f
core_pkg.sv
ctrl_byp_if.sv
if_stage.sv
register_file.sv
controller_bypass.sv
id_stage.sv
ex_stage.sv
wb_stage.sv
core_top.sv
tb_core_top.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_core_top
FILELIST = sim.f
OBJDIR   = obj_dir
PASS     = TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS)"

clean:
	rm -rf $(OBJDIR)
